// ==== common/odd_pipe_defs.svh ====
`ifndef ODD_PIPE_DEFS_SVH
`define ODD_PIPE_DEFS_SVH

// datapath widths
`define QUAD_WIDTH 128
`define ADDR_WIDTH 7
`define UID_WIDTH 3
`define LAT_WIDTH 4
`define PC_WIDTH 32
`define I7_WIDTH 7
`define I16_WIDTH 16

// forward entry, top down: unit id, value, write enable, address, latency
`define ENTRY_WIDTH 143
`define ENT_UID_POS 0
`define ENT_VALUE_POS (`ENT_UID_POS + `UID_WIDTH)
`define ENT_WE_POS (`ENT_VALUE_POS + `QUAD_WIDTH)
`define ENT_ADDR_POS (`ENT_WE_POS + 1)
`define ENT_LAT_POS (`ENT_ADDR_POS + `ADDR_WIDTH)

// number of forwarding stages
`define STAGES 7

// unit ids, zero marks an empty entry
`define UNIT_PERMUTE (`UID_WIDTH'd5)
`define UNIT_BRANCH (`UID_WIDTH'd7)

// stage in which a result becomes forwardable
`define LAT_PERMUTE (`LAT_WIDTH'd4)
`define LAT_BRANCH (`LAT_WIDTH'd1)

`endif

// ==== common/odd_pipe_pkg.sv ====
`include "odd_pipe_defs.svh"

package odd_pipe_pkg;

    // odd pipe opcodes, NOP doubles as the idle slot
    typedef enum logic [4:0] {
        NOP = 5'd0,
        // permute unit
        SHLQBI,
        SHLQBII,
        SHLQBY,
        SHLQBYI,
        ROTQBI,
        ROTQBII,
        ROTQBY,
        ROTQBYI,
        GBB,
        GBH,
        GB,
        // branch unit
        BR,
        BRA,
        BRSL,
        BRASL,
        BRNZ,
        BRZ
    } opcode_t;

    // one register seen as bytes, halfwords or words
    // element 0 is the most significant slice, as in the bit numbering
    typedef union packed {
        logic [0:`QUAD_WIDTH/8-1][0:7] bytes;
        logic [0:`QUAD_WIDTH/16-1][0:15] halfwords;
        logic [0:`QUAD_WIDTH/32-1][0:31] words;
    } quadword_t;

endpackage

// ==== src/forward_pipe.sv ====
`include "odd_pipe_defs.svh"

module forward_pipe (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush,
    input  logic [0:`ENTRY_WIDTH-1] stage_1,
    output logic [0:`ENTRY_WIDTH-1] stage_2,
    output logic [0:`ENTRY_WIDTH-1] stage_3,
    output logic [0:`ENTRY_WIDTH-1] stage_4,
    output logic [0:`ENTRY_WIDTH-1] stage_5,
    output logic [0:`ENTRY_WIDTH-1] stage_6,
    output logic [0:`ENTRY_WIDTH-1] stage_7,
    output logic                    rt_write_en,
    output logic [0:`ADDR_WIDTH-1]  rt_write_address,
    output logic [0:`QUAD_WIDTH-1]  rt_write_value
);

    // every stage advances each cycle, flush squashes the entry leaving stage 1
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_2 <= '0;
            stage_3 <= '0;
            stage_4 <= '0;
            stage_5 <= '0;
            stage_6 <= '0;
            stage_7 <= '0;
        end
        else
        begin
            stage_2 <= flush ? '0 : stage_1;
            stage_3 <= stage_2;
            stage_4 <= stage_3;
            stage_5 <= stage_4;
            stage_6 <= stage_5;
            stage_7 <= stage_6;
        end
    end

    // register file write port from the oldest stage
    assign rt_write_en      = stage_7[`ENT_WE_POS];
    assign rt_write_address = stage_7[`ENT_ADDR_POS +: `ADDR_WIDTH];
    assign rt_write_value   = stage_7[`ENT_VALUE_POS +: `QUAD_WIDTH];

    flush_clears_stage_2: assert property (@(posedge clock) disable iff (reset)
        flush |=> stage_2 == '0);

endmodule

// ==== src/forward_lookup.sv ====
`include "odd_pipe_defs.svh"

module forward_lookup
    import odd_pipe_pkg::*;
(
    input  logic [0:`ENTRY_WIDTH-1] stage_1,
    input  logic [0:`ENTRY_WIDTH-1] stage_2,
    input  logic [0:`ENTRY_WIDTH-1] stage_3,
    input  logic [0:`ENTRY_WIDTH-1] stage_4,
    input  logic [0:`ENTRY_WIDTH-1] stage_5,
    input  logic [0:`ENTRY_WIDTH-1] stage_6,
    input  logic [0:`ENTRY_WIDTH-1] stage_7,
    input  logic [0:`ADDR_WIDTH-1]  query_address,
    output logic                    forward_hit,
    output quadword_t               forward_value
);

    logic [0:`ENTRY_WIDTH-1] stages [1:`STAGES];
    logic                    found;
    logic [0:`UID_WIDTH-1]   chosen_uid;

    assign stages[1] = stage_1;
    assign stages[2] = stage_2;
    assign stages[3] = stage_3;
    assign stages[4] = stage_4;
    assign stages[5] = stage_5;
    assign stages[6] = stage_6;
    assign stages[7] = stage_7;

    // youngest producer of the register decides
    // a producer still short of its latency stage blocks older copies
    always_comb
    begin
        forward_hit   = 1'b0;
        forward_value = '0;
        found         = 1'b0;
        chosen_uid    = '0;
        for (int k = 1; k <= `STAGES; k++)
        begin
            if (!found && stages[k][`ENT_WE_POS]
                && stages[k][`ENT_ADDR_POS +: `ADDR_WIDTH] == query_address)
            begin
                found      = 1'b1;
                chosen_uid = stages[k][`ENT_UID_POS +: `UID_WIDTH];
                if (k >= stages[k][`ENT_LAT_POS +: `LAT_WIDTH])
                begin
                    forward_hit   = 1'b1;
                    forward_value = stages[k][`ENT_VALUE_POS +: `QUAD_WIDTH];
                end
            end
        end
    end

    hit_has_unit: assert #0 (!forward_hit || chosen_uid != '0);

endmodule

// ==== issue/odd_pipe_issue.sv ====
`include "odd_pipe_defs.svh"

module odd_pipe_issue
    import odd_pipe_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  opcode_t                 opcode,
    input  logic [0:`QUAD_WIDTH-1]  ra_value,
    input  logic [0:`QUAD_WIDTH-1]  rb_value,
    input  logic [0:`ADDR_WIDTH-1]  rt_address,
    input  logic [0:`I7_WIDTH-1]    i7,
    input  logic [0:`I16_WIDTH-1]   i16,
    input  logic [0:`PC_WIDTH-1]    pc,
    output logic [0:`ENTRY_WIDTH-1] stage_1,
    output logic                    branch_taken,
    output logic [0:`PC_WIDTH-1]    next_pc,
    output logic                    flush
);

    opcode_t                opcode_q;
    quadword_t              ra_q;
    quadword_t              rb_q;
    logic [0:`ADDR_WIDTH-1] rt_address_q;
    logic [0:`I7_WIDTH-1]   i7_q;
    logic [0:`I16_WIDTH-1]  i16_q;
    logic [0:`PC_WIDTH-1]   pc_q;

    logic [0:`PC_WIDTH-1]   pc_plus_4;
    logic [0:`PC_WIDTH-1]   offset;
    logic [0:`PC_WIDTH-1]   rel_target;
    logic [2:0]             bit_count;
    logic [4:0]             byte_count;
    logic                   is_permute;
    logic                   is_branch;
    quadword_t              result;
    logic [0:`UID_WIDTH-1]  uid;
    logic [0:`LAT_WIDTH-1]  lat;
    logic                   we;

    // byte shift toward byte 0, zero fill or wrap
    function automatic quadword_t permute_bytes(quadword_t src, logic [4:0] count, logic rotate);
        quadword_t  res;
        logic [5:0] idx;
        res = '0;
        for (int b = 0; b < 16; b++)
        begin
            idx = 6'(b) + 6'(count);
            if (rotate)
                res.bytes[b] = src.bytes[idx[3:0]];
            else if (idx < 6'd16)
                res.bytes[b] = src.bytes[idx[3:0]];
        end
        return res;
    endfunction

    always_ff @(posedge clock)
    begin
        if (reset)
            opcode_q <= NOP;
        else
            opcode_q <= opcode;
    end

    always_ff @(posedge clock)
    begin
        ra_q         <= ra_value;
        rb_q         <= rb_value;
        rt_address_q <= rt_address;
        i7_q         <= i7;
        i16_q        <= i16;
        pc_q         <= pc;
    end

    // flush covers the instruction behind a taken branch
    always_ff @(posedge clock)
    begin
        if (reset)
            flush <= 1'b0;
        else
            flush <= branch_taken;
    end

    // word offset, sign extended and scaled by 4
    assign offset     = {{(`PC_WIDTH-`I16_WIDTH-2){i16_q[0]}}, i16_q, 2'b00};
    assign pc_plus_4  = pc_q + `PC_WIDTH'd4;
    assign rel_target = pc_q + offset;

    assign is_permute = opcode_q inside {SHLQBI, SHLQBII, SHLQBY, SHLQBYI, ROTQBI, ROTQBII,
                                         ROTQBY, ROTQBYI, GBB, GBH, GB};
    assign is_branch  = opcode_q inside {BR, BRA, BRSL, BRASL, BRNZ, BRZ};

    // counts from rb word 0 or from i7
    assign bit_count = (opcode_q inside {SHLQBII, ROTQBII}) ? i7_q[`I7_WIDTH-3:`I7_WIDTH-1]
                                                           : rb_q.words[0][29:31];

    always_comb
    begin
        case (opcode_q)
            SHLQBY:  byte_count = rb_q.words[0][27:31];
            SHLQBYI: byte_count = i7_q[`I7_WIDTH-5:`I7_WIDTH-1];
            ROTQBY:  byte_count = {1'b0, rb_q.words[0][28:31]};
            ROTQBYI: byte_count = {1'b0, i7_q[`I7_WIDTH-4:`I7_WIDTH-1]};
            default: byte_count = 5'd0;
        endcase
    end

    always_comb
    begin
        result       = '0;
        we           = 1'b0;
        branch_taken = 1'b0;
        next_pc      = pc_plus_4;
        case (opcode_q)
            SHLQBI, SHLQBII: result = ra_q << bit_count;
            ROTQBI, ROTQBII: result = (ra_q << bit_count) | (ra_q >> (`QUAD_WIDTH - bit_count));
            SHLQBY, SHLQBYI: result = permute_bytes(ra_q, byte_count, 1'b0);
            ROTQBY, ROTQBYI: result = permute_bytes(ra_q, byte_count, 1'b1);
            // gathers pack the last bit of each slice into the low end of word 0
            GBB:
                for (int j = 0; j < 16; j++)
                    result.words[0][16+j] = ra_q.bytes[j][7];
            GBH:
                for (int j = 0; j < 8; j++)
                    result.words[0][24+j] = ra_q.halfwords[j][15];
            GB:
                for (int j = 0; j < 4; j++)
                    result.words[0][28+j] = ra_q.words[j][31];
            BR, BRSL:
            begin
                branch_taken = 1'b1;
                next_pc      = rel_target;
            end
            BRA, BRASL:
            begin
                branch_taken = 1'b1;
                next_pc      = offset;
            end
            BRNZ:
            begin
                branch_taken = (rb_q.words[0] != '0);
                if (branch_taken)
                    next_pc = rel_target;
            end
            BRZ:
            begin
                branch_taken = (rb_q.words[0] == '0);
                if (branch_taken)
                    next_pc = rel_target;
            end
            default: ;
        endcase
        // link forms return pc+4 in word 0
        if (opcode_q inside {BRSL, BRASL})
        begin
            result.words[0] = pc_plus_4;
            we              = 1'b1;
        end
        if (is_permute)
            we = 1'b1;
    end

    assign uid = is_permute ? `UNIT_PERMUTE : (is_branch ? `UNIT_BRANCH : '0);
    assign lat = is_permute ? `LAT_PERMUTE : (is_branch ? `LAT_BRANCH : '0);

    // nop leaves an empty entry, address included
    assign stage_1 = (is_permute || is_branch) ? {uid, result, we, rt_address_q, lat} : '0;

    taken_needs_branch_op: assert property (@(posedge clock) disable iff (reset)
        branch_taken |-> $past(opcode) inside {BR, BRA, BRSL, BRASL, BRNZ, BRZ});

endmodule

// ==== src/odd_pipe.sv ====
`include "odd_pipe_defs.svh"

module odd_pipe
    import odd_pipe_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  opcode_t                 opcode,
    input  logic [0:`QUAD_WIDTH-1]  ra_value,
    input  logic [0:`QUAD_WIDTH-1]  rb_value,
    input  logic [0:`ADDR_WIDTH-1]  rt_address,
    input  logic [0:`I7_WIDTH-1]    i7,
    input  logic [0:`I16_WIDTH-1]   i16,
    input  logic [0:`PC_WIDTH-1]    pc,
    input  logic [0:`ADDR_WIDTH-1]  query_address,
    output logic [0:`ENTRY_WIDTH-1] stage_1,
    output logic [0:`ENTRY_WIDTH-1] stage_2,
    output logic [0:`ENTRY_WIDTH-1] stage_3,
    output logic [0:`ENTRY_WIDTH-1] stage_4,
    output logic [0:`ENTRY_WIDTH-1] stage_5,
    output logic [0:`ENTRY_WIDTH-1] stage_6,
    output logic [0:`ENTRY_WIDTH-1] stage_7,
    output logic                    branch_taken,
    output logic [0:`PC_WIDTH-1]    next_pc,
    output logic                    flush,
    output logic                    rt_write_en,
    output logic [0:`ADDR_WIDTH-1]  rt_write_address,
    output logic [0:`QUAD_WIDTH-1]  rt_write_value,
    output logic                    forward_hit,
    output quadword_t               forward_value
);

    // operand capture and execution, produces the stage 1 entry
    odd_pipe_issue issue_i (
        .clock        (clock),
        .reset        (reset),
        .opcode       (opcode),
        .ra_value     (ra_value),
        .rb_value     (rb_value),
        .rt_address   (rt_address),
        .i7           (i7),
        .i16          (i16),
        .pc           (pc),
        .stage_1      (stage_1),
        .branch_taken (branch_taken),
        .next_pc      (next_pc),
        .flush        (flush)
    );

    forward_pipe pipe_i (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .stage_1          (stage_1),
        .stage_2          (stage_2),
        .stage_3          (stage_3),
        .stage_4          (stage_4),
        .stage_5          (stage_5),
        .stage_6          (stage_6),
        .stage_7          (stage_7),
        .rt_write_en      (rt_write_en),
        .rt_write_address (rt_write_address),
        .rt_write_value   (rt_write_value)
    );

    forward_lookup lookup_i (
        .stage_1       (stage_1),
        .stage_2       (stage_2),
        .stage_3       (stage_3),
        .stage_4       (stage_4),
        .stage_5       (stage_5),
        .stage_6       (stage_6),
        .stage_7       (stage_7),
        .query_address (query_address),
        .forward_hit   (forward_hit),
        .forward_value (forward_value)
    );

endmodule

// ==== sim/odd_pipe_tb.sv ====
`include "odd_pipe_defs.svh"

module odd_pipe_tb
    import odd_pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_INSTR = 500;
    localparam int MAX_CYCLES = RESET_CYCLES + NUM_INSTR + 96;
    // entry field positions with bit 0 as the least significant bit
    localparam int VALUE_TOP = `ENTRY_WIDTH - `UID_WIDTH - 1;
    localparam int WE_BIT = VALUE_TOP - `QUAD_WIDTH;
    localparam int ADDR_TOP = WE_BIT - 1;

    logic clock = 1'b0;
    logic reset;
    opcode_t opcode;
    logic [`QUAD_WIDTH-1:0] ra_value, rb_value, rt_write_value, forward_value;
    logic [`ADDR_WIDTH-1:0] rt_address, query_address, rt_write_address;
    logic [`I7_WIDTH-1:0] i7;
    logic [`I16_WIDTH-1:0] i16;
    logic [`PC_WIDTH-1:0] pc, next_pc;
    logic [`ENTRY_WIDTH-1:0] stage_1, stage_2, stage_3, stage_4, stage_5, stage_6, stage_7;
    logic branch_taken, flush, rt_write_en, forward_hit;

    // predicted pipeline contents
    logic [`ENTRY_WIDTH-1:0] model_stage [1:`STAGES];
    logic model_taken, model_flush;
    logic [`PC_WIDTH-1:0] model_next_pc;
    integer seed;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    odd_pipe dut_i (.*);

    always #20 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // shift toward the most significant end (bit 0 in the core's numbering)
    function automatic logic [`QUAD_WIDTH-1:0] shift_left(input logic [`QUAD_WIDTH-1:0] v,
                                                          input int n, input bit rotate);
        logic [`QUAD_WIDTH-1:0] res;
        int src;
        res = '0;
        for (int i = 0; i < `QUAD_WIDTH; i++)
        begin
            src = i - n;
            if (src >= 0)
                res[i] = v[src];
            else if (rotate)
                res[i] = v[src + `QUAD_WIDTH];
        end
        return res;
    endfunction

    // last bit of each slice packed at the low end of word 0 with the top slice first
    function automatic logic [`QUAD_WIDTH-1:0] gather_low_bits(input logic [`QUAD_WIDTH-1:0] v,
                                                               input int size);
        logic [`QUAD_WIDTH-1:0] res;
        int slices;
        res = '0;
        slices = `QUAD_WIDTH / size;
        for (int j = 0; j < slices; j++)
            res[`QUAD_WIDTH - 32 + slices - 1 - j] = v[`QUAD_WIDTH - size * (j + 1)];
        return res;
    endfunction

    // entry for the instruction now on the inputs as it appears once captured
    task automatic predict_entry();
        logic [`QUAD_WIDTH-1:0] value;
        logic [`PC_WIDTH-1:0] offset;
        logic [31:0] rb_word;
        logic [`UID_WIDTH-1:0] uid;
        logic [`LAT_WIDTH-1:0] lat;
        logic we;
        value = '0;
        we = 1'b0;
        uid = '0;
        lat = '0;
        rb_word = rb_value[`QUAD_WIDTH-1 -: 32];
        offset = {{(`PC_WIDTH - `I16_WIDTH){i16[`I16_WIDTH-1]}}, i16} << 2;
        model_taken = 1'b0;
        model_next_pc = pc + 4;
        case (opcode)
            SHLQBI:  value = shift_left(ra_value, rb_word[2:0], 1'b0);
            SHLQBII: value = shift_left(ra_value, i7[2:0], 1'b0);
            ROTQBI:  value = shift_left(ra_value, rb_word[2:0], 1'b1);
            ROTQBII: value = shift_left(ra_value, i7[2:0], 1'b1);
            SHLQBY:  value = shift_left(ra_value, 8 * rb_word[4:0], 1'b0);
            SHLQBYI: value = shift_left(ra_value, 8 * i7[4:0], 1'b0);
            ROTQBY:  value = shift_left(ra_value, 8 * rb_word[3:0], 1'b1);
            ROTQBYI: value = shift_left(ra_value, 8 * i7[3:0], 1'b1);
            GBB:     value = gather_low_bits(ra_value, 8);
            GBH:     value = gather_low_bits(ra_value, 16);
            GB:      value = gather_low_bits(ra_value, 32);
            BR, BRSL, BRA, BRASL:
            begin
                model_taken = 1'b1;
                model_next_pc = (opcode inside {BRA, BRASL}) ? offset : pc + offset;
            end
            BRNZ, BRZ:
            begin
                model_taken = (opcode == BRNZ) ? (rb_word != 0) : (rb_word == 0);
                if (model_taken)
                    model_next_pc = pc + offset;
            end
            default: ;
        endcase
        if (opcode inside {BRSL, BRASL})
        begin
            value[`QUAD_WIDTH-1 -: 32] = pc + 4;
            we = 1'b1;
        end
        if (opcode inside {BR, BRA, BRSL, BRASL, BRNZ, BRZ})
        begin
            uid = `UNIT_BRANCH;
            lat = `LAT_BRANCH;
        end
        else if (opcode != NOP)
        begin
            uid = `UNIT_PERMUTE;
            lat = `LAT_PERMUTE;
            we = 1'b1;
        end
        model_stage[1] = (opcode == NOP) ? '0 : {uid, value, we, rt_address, lat};
    endtask

    // one clock edge of the model
    task automatic shift_model_pipe();
        for (int k = `STAGES; k > 2; k--)
            model_stage[k] = model_stage[k-1];
        model_stage[2] = model_flush ? '0 : model_stage[1];
        model_flush = model_taken;
        predict_entry();
    endtask

    task automatic search_forward(output logic hit, output logic [`QUAD_WIDTH-1:0] value);
        logic found;
        found = 1'b0;
        hit = 1'b0;
        value = '0;
        for (int k = 1; k <= `STAGES; k++)
        begin
            if (!found && model_stage[k][WE_BIT]
                && model_stage[k][ADDR_TOP -: `ADDR_WIDTH] == query_address)
            begin
                found = 1'b1;
                if (k >= model_stage[k][`LAT_WIDTH-1:0])
                begin
                    hit = 1'b1;
                    value = model_stage[k][VALUE_TOP -: `QUAD_WIDTH];
                end
            end
        end
    endtask

    task automatic check_value(input string what, input logic [`ENTRY_WIDTH-1:0] got,
                               input logic [`ENTRY_WIDTH-1:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_outputs();
        logic hit;
        logic [`QUAD_WIDTH-1:0] value;
        search_forward(hit, value);
        check_value("stage_1", stage_1, model_stage[1]);
        check_value("stage_2", stage_2, model_stage[2]);
        check_value("stage_3", stage_3, model_stage[3]);
        check_value("stage_4", stage_4, model_stage[4]);
        check_value("stage_5", stage_5, model_stage[5]);
        check_value("stage_6", stage_6, model_stage[6]);
        check_value("stage_7", stage_7, model_stage[7]);
        check_value("branch_taken", branch_taken, model_taken);
        check_value("flush", flush, model_flush);
        if (model_stage[1][`ENTRY_WIDTH-1 -: `UID_WIDTH] == `UNIT_BRANCH)
            check_value("next_pc", next_pc, model_next_pc);
        check_value("rt_write_en", rt_write_en, model_stage[7][WE_BIT]);
        check_value("rt_write_address", rt_write_address, model_stage[7][ADDR_TOP -: `ADDR_WIDTH]);
        check_value("rt_write_value", rt_write_value, model_stage[7][VALUE_TOP -: `QUAD_WIDTH]);
        check_value("forward_hit", forward_hit, hit);
        check_value("forward_value", forward_value, value);
    endtask

    // addresses from a small range so that lookups find producers
    task automatic drive_inputs(input bit active);
        opcode = active ? opcode_t'($unsigned($random(seed)) % 18) : NOP;
        ra_value = {$random(seed), $random(seed), $random(seed), $random(seed)};
        rb_value = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if ($unsigned($random(seed)) % 4 == 0)
            rb_value[`QUAD_WIDTH-1 -: 32] = '0;
        rt_address = $unsigned($random(seed)) % 4;
        i7 = $random(seed);
        i16 = $random(seed);
        pc = $random(seed) & 32'hffff_fffc;
        query_address = $unsigned($random(seed)) % 4;
    endtask

    initial
    begin
        seed = 7;
        reset = 1'b1;
        // a taken branch held on the inputs during reset must not be captured
        opcode = BR;
        ra_value = '0;
        rb_value = '0;
        rt_address = '0;
        i7 = '0;
        i16 = '0;
        pc = '0;
        query_address = '0;
        for (int k = 1; k <= `STAGES; k++)
            model_stage[k] = '0;
        model_taken = 1'b0;
        model_flush = 1'b0;
        model_next_pc = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        // the last cycles drain the pipe with nops
        for (int n = 0; n < NUM_INSTR + `STAGES + 1; n++)
        begin
            drive_inputs(n < NUM_INSTR);
            @(negedge clock);
            check_outputs();
            @(posedge clock);
            #2;
            shift_model_pipe();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== odd_pipe.f ====
+incdir+common
common/odd_pipe_pkg.sv
src/forward_pipe.sv
src/forward_lookup.sv
issue/odd_pipe_issue.sv
src/odd_pipe.sv
sim/odd_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: odd_pipe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/odd_pipe_pkg.sv
      - src/forward_pipe.sv
      - src/forward_lookup.sv
      - issue/odd_pipe_issue.sv
      - src/odd_pipe.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/odd_pipe_tb.sv
